//--- include/rx_params.svh
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// receive FIFO depth in entries, a power of two.
`define RX_FIFO_DEPTH 8

// Wishbone word addresses of the register map.
`define RX_REG_CTRL     4'h0
`define RX_REG_DIV_LS   4'h1
`define RX_REG_DIV_HS   4'h2
`define RX_REG_IDLE_LEN 4'h3
`define RX_REG_STATUS   4'h4
`define RX_REG_DATA     4'h5

`define RX_WB_AW 4
`define RX_WB_DW 32

// CRC-16/MODBUS, reflected form shifted in LSB first.
`define RX_CRC_POLY 16'hA001
`define RX_CRC_INIT 16'hFFFF

`endif

//--- logic/rx_pkg.sv
`include "rx_params.svh"

package rx_pkg;

    // request from the Wishbone master to the register block.
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`RX_WB_AW-1:0]  adr;
        logic [`RX_WB_DW-1:0]  dat;
    } wb_req_t;

    // response back to the master.
    typedef struct packed {
        logic [`RX_WB_DW-1:0]  dat;
        logic                  ack;
    } wb_rsp_t;

    // one received byte and the running CRC after it.
    // crc sits above data so the entry maps straight onto the DATA register.
    typedef struct packed {
        logic [15:0]           crc;
        logic [7:0]            data;
    } rx_entry_t;

endpackage

//--- logic/baud_rate.sv
`timescale 1ns/1ps

module baud_rate (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        sync,
    input  logic [15:0] div_ls,
    input  logic [15:0] div_hs,
    input  logic        sel,
    output logic        inc,
    output logic        cap
);

    logic [15:0] cnt;
    logic [15:0] div;

    assign div = sel ? div_hs : div_ls; // sel high picks the data rate.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= '0;
        end else if (sync || cnt >= div) begin
            cnt <= '0; // also wraps if sel moved to a shorter period.
        end else begin
            cnt <= cnt + 16'd1;
        end
    end

    // both strobes stay quiet while the count is being restarted.
    assign inc = !sync && (cnt >= div);
    assign cap = !sync && (cnt == {1'b0, div[15:1]}); // middle of the bit.

endmodule

//--- logic/serial_crc.sv
`timescale 1ns/1ps
`include "rx_params.svh"

module serial_crc (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clean,
    input  logic        data_clk,
    input  logic        data_in,
    output logic [15:0] crc_out
);

    logic feedback;

    assign feedback = crc_out[0] ^ data_in;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_out <= `RX_CRC_INIT;
        end else if (clean) begin
            crc_out <= `RX_CRC_INIT;
        end else if (data_clk) begin
            // reflected register, so the shift goes toward bit 0.
            crc_out <= {1'b0, crc_out[15:1]} ^ (feedback ? `RX_CRC_POLY : 16'h0000);
        end
    end

endmodule

//--- logic/rx_des.sv
`timescale 1ns/1ps

module rx_des (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [15:0]       div_ls,
    input  logic [15:0]       div_hs,
    input  logic [7:0]        idle_wait_len,
    input  logic              force_wait_idle,
    input  logic              rx,
    output logic              bus_idle,
    output logic              rx_break,
    output rx_pkg::rx_entry_t entry,
    output logic              data_clk
);

    localparam logic [3:0] WAIT_IDLE = 4'b0001;
    localparam logic [3:0] WAIT_DATA = 4'b0010;
    localparam logic [3:0] BUS_IDLE  = 4'b0100;
    localparam logic [3:0] DATA      = 4'b1000;

    logic [3:0]  state;
    logic [1:0]  rx_d;
    logic        rx_s;
    logic [7:0]  idle_cnt;
    logic        idle_done;
    logic [3:0]  bit_cnt; // 0 is the start bit, 9 the stop bit.
    logic [7:0]  shift;
    logic        first_byte;
    logic        baud_sync;
    logic        baud_sel;
    logic        bit_inc;
    logic        bit_cap;
    logic        data_bit;
    logic        bit_err;
    logic        byte_end;
    logic        crc_clk;
    logic [15:0] crc_val;

    // rx comes straight off the transceiver.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_d <= 2'b11; // line idles high.
        end else begin
            rx_d <= {rx_d[0], rx};
        end
    end

    assign rx_s      = rx_d[1];
    assign bus_idle  = (state == BUS_IDLE);
    assign idle_done = (idle_cnt >= idle_wait_len);

    // outside a byte the counter follows every low level of the line, so a start edge
    // begins the bit period from zero.
    assign baud_sync = (state != DATA) && (!rx_s || state == BUS_IDLE);
    assign baud_sel  = (state == DATA) ? !first_byte : 1'b1;

    assign bit_err  = (state == DATA) && bit_cap && (bit_cnt == 4'd0) && rx_s;
    assign byte_end = (state == DATA) && bit_cap && (bit_cnt == 4'd9);
    assign data_bit = (state == DATA) && bit_cap && (bit_cnt >= 4'd1) && (bit_cnt <= 4'd8);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= WAIT_IDLE;
            first_byte <= 1'b1;
        end else if (force_wait_idle) begin
            state <= WAIT_IDLE;
        end else begin
            case (state)
                WAIT_IDLE: begin
                    first_byte <= 1'b1;
                    if (idle_done) begin
                        state <= BUS_IDLE;
                    end
                end
                WAIT_DATA: begin
                    if (!rx_s) begin
                        state <= DATA; // next byte of the same frame.
                    end else if (idle_done) begin
                        state <= BUS_IDLE;
                    end
                end
                BUS_IDLE: begin
                    first_byte <= 1'b1;
                    if (!rx_s) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (bit_err) begin
                        state <= WAIT_IDLE; // glitch, not a real start bit.
                    end else if (byte_end) begin
                        state      <= rx_s ? WAIT_DATA : WAIT_IDLE;
                        first_byte <= 1'b0;
                    end
                end
                default: state <= WAIT_IDLE;
            endcase
        end
    end

    // idle bit times, saturating at the programmed length.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_cnt <= '0;
        end else if (state == DATA || !rx_s) begin
            idle_cnt <= '0;
        end else if (bit_inc && !idle_done) begin
            idle_cnt <= idle_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt  <= '0;
            data_clk <= 1'b0;
            rx_break <= 1'b0;
            crc_clk  <= 1'b0;
        end else begin
            data_clk <= 1'b0;
            rx_break <= 1'b0;
            crc_clk  <= data_bit;
            if (state != DATA || force_wait_idle) begin
                bit_cnt <= '0; // a forced idle drops whatever was half received.
            end else if (bit_cap) begin
                if (bit_cnt == 4'd9) begin
                    bit_cnt  <= '0;
                    data_clk <= rx_s;
                    rx_break <= !rx_s; // low stop bit.
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_bit) begin
            shift <= {rx_s, shift[7:1]}; // LSB arrives first.
        end
    end

    baud_rate u_baud_rate (
        .clk     (clk),
        .reset_n (reset_n),
        .sync    (baud_sync),
        .div_ls  (div_ls),
        .div_hs  (div_hs),
        .sel     (baud_sel),
        .inc     (bit_inc),
        .cap     (bit_cap)
    );

    // the bit shifted in one cycle ago now sits at shift[7].
    serial_crc u_serial_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (state == BUS_IDLE),
        .data_clk (crc_clk),
        .data_in  (shift[7]),
        .crc_out  (crc_val)
    );

    assign entry.data = shift;
    assign entry.crc  = crc_val;

endmodule

//--- logic/rx_fifo.sv
`timescale 1ns/1ps
`include "rx_params.svh"

module rx_fifo (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              wr,
    input  rx_pkg::rx_entry_t wr_entry,
    input  logic              rd,
    output rx_pkg::rx_entry_t rd_entry,
    output logic [3:0]        count,
    output logic              overflow,
    input  logic              clr_overflow
);

    import rx_pkg::*;

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    rx_entry_t      mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           full;
    logic           empty;
    logic           do_wr;
    logic           do_rd;

    assign full  = (count == 4'(DEPTH));
    assign empty = (count == 4'd0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            count <= count + 4'(do_wr) - 4'(do_rd);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            overflow <= 1'b0;
        end else if (wr && full) begin
            overflow <= 1'b1; // a new drop wins over a clear in the same cycle.
        end else if (clr_overflow) begin
            overflow <= 1'b0;
        end
    end

    assign rd_entry = mem[rd_ptr];

endmodule

//--- logic/rx_wb_regs.sv
`timescale 1ns/1ps
`include "rx_params.svh"

module rx_wb_regs (
    input  logic              clk,
    input  logic              reset_n,
    input  rx_pkg::wb_req_t   wb_req,
    output rx_pkg::wb_rsp_t   wb_rsp,
    output logic [15:0]       div_ls,
    output logic [15:0]       div_hs,
    output logic [7:0]        idle_wait_len,
    output logic              force_wait_idle,
    input  logic              bus_idle,
    input  logic              rx_break,
    input  logic [3:0]        fifo_count,
    input  rx_pkg::rx_entry_t fifo_head,
    input  logic              fifo_overflow,
    output logic              fifo_pop,
    output logic              clr_overflow
);

    localparam int DW = `RX_WB_DW;

    logic          ack;
    logic [DW-1:0] rd_dat;
    logic [DW-1:0] rd_mux;
    logic          acc;
    logic          wr_acc;
    logic          rd_acc;
    logic          break_flag;
    logic          fifo_nempty;

    // a new access is taken once, the cycle before its ack.
    assign acc         = wb_req.cyc && wb_req.stb && !ack;
    assign wr_acc      = acc && wb_req.we;
    assign rd_acc      = acc && !wb_req.we;
    assign fifo_nempty = (fifo_count != 4'd0);

    always_comb begin
        rd_mux = '0;
        case (wb_req.adr)
            `RX_REG_DIV_LS:   rd_mux = DW'(div_ls);
            `RX_REG_DIV_HS:   rd_mux = DW'(div_hs);
            `RX_REG_IDLE_LEN: rd_mux = DW'(idle_wait_len);
            `RX_REG_STATUS:   rd_mux = DW'({fifo_count, 4'b0000, break_flag, fifo_overflow,
                                            fifo_nempty, bus_idle});
            `RX_REG_DATA:     rd_mux = fifo_nempty ? DW'(fifo_head) : '0;
            default:          rd_mux = '0; // CTRL reads as zero.
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack             <= 1'b0;
            div_ls          <= '0;
            div_hs          <= '0;
            idle_wait_len   <= '0;
            force_wait_idle <= 1'b0;
            fifo_pop        <= 1'b0;
            clr_overflow    <= 1'b0;
        end else begin
            ack             <= acc;
            force_wait_idle <= wr_acc && (wb_req.adr == `RX_REG_CTRL) && wb_req.dat[0];
            clr_overflow    <= wr_acc && (wb_req.adr == `RX_REG_STATUS) && wb_req.dat[2];
            // pop lands in the ack cycle, after the head has been captured.
            fifo_pop        <= rd_acc && (wb_req.adr == `RX_REG_DATA) && fifo_nempty;
            if (wr_acc) begin
                case (wb_req.adr)
                    `RX_REG_DIV_LS:   div_ls        <= wb_req.dat[15:0];
                    `RX_REG_DIV_HS:   div_hs        <= wb_req.dat[15:0];
                    `RX_REG_IDLE_LEN: idle_wait_len <= wb_req.dat[7:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            break_flag <= 1'b0;
        end else if (rx_break) begin
            break_flag <= 1'b1;
        end else if (wr_acc && wb_req.adr == `RX_REG_STATUS && wb_req.dat[3]) begin
            break_flag <= 1'b0; // write one to clear.
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_dat <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

endmodule

//--- logic/cdbus_rx_top.sv
`timescale 1ns/1ps

module cdbus_rx_top (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            rx,
    input  rx_pkg::wb_req_t wb_req,
    output rx_pkg::wb_rsp_t wb_rsp,
    output logic            bus_idle
);

    import rx_pkg::*;

    logic [15:0] div_ls;
    logic [15:0] div_hs;
    logic [7:0]  idle_wait_len;
    logic        force_wait_idle;
    logic        rx_break;
    rx_entry_t   rx_entry;
    logic        data_clk;
    rx_entry_t   fifo_head;
    logic [3:0]  fifo_count;
    logic        fifo_overflow;
    logic        fifo_pop;
    logic        clr_overflow;

    rx_des u_rx_des (
        .clk             (clk),
        .reset_n         (reset_n),
        .div_ls          (div_ls),
        .div_hs          (div_hs),
        .idle_wait_len   (idle_wait_len),
        .force_wait_idle (force_wait_idle),
        .rx              (rx),
        .bus_idle        (bus_idle),
        .rx_break        (rx_break),
        .entry           (rx_entry),
        .data_clk        (data_clk)
    );

    rx_fifo u_rx_fifo (
        .clk          (clk),
        .reset_n      (reset_n),
        .wr           (data_clk),
        .wr_entry     (rx_entry),
        .rd           (fifo_pop),
        .rd_entry     (fifo_head),
        .count        (fifo_count),
        .overflow     (fifo_overflow),
        .clr_overflow (clr_overflow)
    );

    rx_wb_regs u_rx_wb_regs (
        .clk             (clk),
        .reset_n         (reset_n),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .div_ls          (div_ls),
        .div_hs          (div_hs),
        .idle_wait_len   (idle_wait_len),
        .force_wait_idle (force_wait_idle),
        .bus_idle        (bus_idle),
        .rx_break        (rx_break),
        .fifo_count      (fifo_count),
        .fifo_head       (fifo_head),
        .fifo_overflow   (fifo_overflow),
        .fifo_pop        (fifo_pop),
        .clr_overflow    (clr_overflow)
    );

endmodule

//--- verif/cdbus_rx_asserts.sv
`timescale 1ns/1ps
`include "rx_params.svh"

module cdbus_rx_asserts (
    input logic            clk,
    input logic            reset_n,
    input rx_pkg::wb_req_t wb_req,
    input rx_pkg::wb_rsp_t wb_rsp,
    input logic [3:0]      fifo_count,
    input logic            data_clk,
    input logic            rx_break
);

    int fail_count = 0; // the testbench looks at this when the run ends.

    // no wait states, so ack is a single pulse.
    ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_count++;
            $error("Wishbone ack stayed high for more than one cycle");
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            fail_count++;
            $error("Wishbone ack came without cyc and stb");
        end

    count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_count <= `RX_FIFO_DEPTH)
        else begin
            fail_count++;
            $error("FIFO count went above the FIFO depth");
        end

    // a stop bit is either high or low, never both.
    byte_or_break: assert property (@(posedge clk) disable iff (!reset_n)
        !(data_clk && rx_break))
        else begin
            fail_count++;
            $error("data_clk and rx_break fired in the same cycle");
        end

endmodule

bind cdbus_rx_top cdbus_rx_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .fifo_count (fifo_count),
    .data_clk   (data_clk),
    .rx_break   (rx_break)
);

//--- verif/tb_cdbus_rx.sv
`timescale 1ns/1ps
`include "rx_params.svh"

module tb_cdbus_rx;

    import rx_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    localparam int DIV_LS    = 31; // 32 clocks per arbitration bit.
    localparam int DIV_HS    = 7;  // 8 clocks per data bit.
    localparam int IDLE_LEN  = 8;
    localparam int IDLE_HOLD = (IDLE_LEN + 3) * (DIV_HS + 1); // line high after each frame.
    // the seven frames carry seven bytes at the low rate and eighteen at the high rate.
    localparam int LINE_CYCLES = 10 * (7 * (DIV_LS + 1) + 18 * (DIV_HS + 1)) + 7 * IDLE_HOLD;
    localparam int TIMEOUT     = 2 * LINE_CYCLES + 2000;

    logic        clk;
    logic        reset_n;
    logic        rx;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        bus_idle;
    logic [31:0] rng;
    int          cycles = 0;
    rx_entry_t   exp_q[$]; // entries the FIFO should hold with the oldest at the front.

    cdbus_rx_top DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx       (rx),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .bus_idle (bus_idle)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT);
            $display("TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] rand_byte();
        rng = xorshift32(rng);
        return rng[7:0];
    endfunction

    function automatic byte_q_t random_frame(input int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(rand_byte());
        end
        return q;
    endfunction

    // works CRC-16/MODBUS over the bytes of one frame a byte at a time.
    function automatic logic [15:0] ref_crc(input byte_q_t bytes);
        logic [15:0] crc;
        crc = `RX_CRC_INIT;
        foreach (bytes[i]) begin
            crc = crc ^ {8'h00, bytes[i]};
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ `RX_CRC_POLY) : (crc >> 1);
            end
        end
        return crc;
    endfunction

    function automatic logic [31:0] status_word(input int count, input logic ovf, input logic brk);
        return {20'h00000, 4'(count), 4'h0, brk, ovf, (count != 0), 1'b1}; // bus is idle.
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wb_access(input logic we, input logic [`RX_WB_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk); // stb stays up through the ack cycle.
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [`RX_WB_AW-1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [`RX_WB_AW-1:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic send_byte(input logic [7:0] data, input int div, input logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0}; // the start bit goes out first and the data follows LSB first.
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            wait_cycles(div + 1);
        end
    endtask

    // the first byte runs at the arbitration rate, the rest at the data rate.
    task automatic send_frame(input byte_q_t bytes, input logic stop, input logic record);
        byte_q_t   sent;
        rx_entry_t e;
        foreach (bytes[i]) begin
            send_byte(bytes[i], (i == 0) ? DIV_LS : DIV_HS, stop);
            sent.push_back(bytes[i]);
            if (record) begin
                e.data = bytes[i];
                e.crc  = ref_crc(sent);
                exp_q.push_back(e);
            end
        end
        rx = 1'b1;
        wait_cycles(IDLE_HOLD);
    endtask

    task automatic check_fifo(input logic ovf);
        logic [31:0] rdat;
        rx_entry_t   e;
        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(exp_q.size(), ovf, 1'b0), "status before draining");
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            wb_read(`RX_REG_DATA, rdat);
            check_eq(rdat, {8'h00, e.crc, e.data}, "fifo entry");
        end
        wb_read(`RX_REG_DATA, rdat);
        check_eq(rdat, 32'h0, "read of an empty fifo");
    endtask

    initial begin
        logic [31:0] rdat;
        byte_q_t     frame;
        clk     = 1'b0;
        reset_n = 1'b0;
        rx      = 1'b1;
        wb_req  = '0;
        rng     = 32'd45354;
        wait_cycles(4);
        reset_n = 1'b1;
        wait_cycles(2);

        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(0, 1'b0, 1'b0), "status after reset");
        wb_write(`RX_REG_DIV_LS, 32'(DIV_LS));
        wb_write(`RX_REG_DIV_HS, 32'(DIV_HS));
        wb_write(`RX_REG_IDLE_LEN, 32'(IDLE_LEN));
        wb_read(`RX_REG_DIV_LS, rdat);
        check_eq(rdat, 32'(DIV_LS), "DIV_LS readback");
        wb_read(`RX_REG_DIV_HS, rdat);
        check_eq(rdat, 32'(DIV_HS), "DIV_HS readback");
        wb_read(`RX_REG_IDLE_LEN, rdat);
        check_eq(rdat, 32'(IDLE_LEN), "IDLE_LEN readback");

        frame = random_frame(1);
        send_frame(frame, 1'b1, 1'b1);
        check_eq({31'b0, bus_idle}, 32'h1, "bus idle after a one-byte frame");
        check_fifo(1'b0);

        repeat (2) begin // each frame starts its CRC from the seed.
            frame = random_frame(5);
            send_frame(frame, 1'b1, 1'b1);
            check_eq({31'b0, bus_idle}, 32'h1, "bus idle after a five-byte frame");
            check_fifo(1'b0);
        end

        frame = random_frame(1);
        send_frame(frame, 1'b0, 1'b0); // low stop bit.
        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(0, 1'b0, 1'b1), "break flag set");
        wb_write(`RX_REG_STATUS, 32'h8);
        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(0, 1'b0, 1'b0), "break flag cleared");

        frame = random_frame(10);
        send_frame(frame, 1'b1, 1'b1);
        while (exp_q.size() > `RX_FIFO_DEPTH) begin
            exp_q.delete(exp_q.size() - 1); // bytes past a full FIFO are lost.
        end
        check_fifo(1'b1);
        wb_write(`RX_REG_STATUS, 32'h4);
        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(0, 1'b0, 1'b0), "overflow flag cleared");

        frame = {8'h55}; // alternating bits keep the line from looking idle after the abort.
        fork
            send_frame(frame, 1'b1, 1'b0);
            begin
                wait_cycles(4 * (DIV_LS + 1));
                wb_write(`RX_REG_CTRL, 32'h1);
            end
        join
        wb_read(`RX_REG_STATUS, rdat);
        check_eq(rdat, status_word(0, 1'b0, 1'b0), "no entry from the aborted byte");
        frame = random_frame(2);
        send_frame(frame, 1'b1, 1'b1);
        check_fifo(1'b0);

        if (DUT.u_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
logic/rx_pkg.sv
logic/baud_rate.sv
logic/serial_crc.sv
logic/rx_des.sv
logic/rx_fifo.sv
logic/rx_wb_regs.sv
logic/cdbus_rx_top.sv
verif/cdbus_rx_asserts.sv
verif/tb_cdbus_rx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cdbus_rx
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0
RUN_FLAGS ?= +verilator+error+limit+100

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --assert --timing $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
